// ==== Makefile ====
# Verilator simulation of the pc front end

VERILATOR ?= verilator
TOP       ?= pc_front_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
+incdir+include
logic/fe_pkg.sv
logic/fetch_predecode.sv
logic/new_pc.sv
logic/fetch_pc_reg.sv
logic/pc_front.sv
verif/pc_front_tb.sv

// ==== include/fe_defs.svh ====
// ==========================================================
// front end definitions
// widths, reset vector and RV32 major opcodes for fetch
// ==========================================================

`ifndef FE_DEFS_SVH
`define FE_DEFS_SVH

// data, address and instruction width
`define FE_XLEN 32

// first fetch address after reset
`define FE_RESET_PC 32'h0000_1000

// RV32 major opcodes seen by predecode
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL    7'b1101111
// jalr is not predicted, fixed up at commit
`define FE_OPC_JALR   7'b1100111

`endif

// ==== logic/fe_pkg.sv ====
// ==========================================================
// front end types
// instruction views, fetch pipe record, commit and issue
// ==========================================================

`include "fe_defs.svh"

package fe_pkg;

    // B-type layout, conditional branches
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    // J-type layout, jal
    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, read either way
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } rv_instr_u;

    // fetched instruction plus predecode result
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        rv_instr_u           instruction;
        logic                branch;
        logic                jump;
        logic                prediction;
    } pipe_t;

    // state of the instruction at the ROB head
    typedef struct packed {
        logic [`FE_XLEN-1:0] pc;
        logic [`FE_XLEN-1:0] imm_se;
        logic                taken;
        logic                result;
        logic                is_branch;
        logic                jalr;
        logic [`FE_XLEN-1:0] jalr_taken_address;
        logic [`FE_XLEN-1:0] jalr_actual_address;
    } commit_t;

    // one entry toward the issue queue
    typedef struct packed {
        logic                valid;
        logic [`FE_XLEN-1:0] pc;
        rv_instr_u           instruction;
        logic                prediction;
    } issue_t;

endpackage

// ==== logic/fetch_pc_reg.sv ====
// ==========================================================
// fetch pc register
// holds pc on a full queue, redirects on mispredict,
// registers the record handed to the issue queue
// ==========================================================

`include "fe_defs.svh"

module fetch_pc_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                queue_full,
    input  logic                mispredicted,
    input  logic [`FE_XLEN-1:0] pc_update,
    input  fe_pkg::pipe_t       pipe,
    output logic [`FE_XLEN-1:0] fetch_pc,
    output fe_pkg::issue_t      issue
);

    logic          advance;
    logic          issue_en;
    logic          issue_valid;
    fe_pkg::pipe_t issue_pipe;

    // a redirect overrides back-pressure since the queue is flushed anyway
    assign advance  = ~queue_full | mispredicted;
    // flushed cycles hand nothing over
    assign issue_en = advance & ~mispredicted;

    // pc and valid flag
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc    <= `FE_RESET_PC;
            issue_valid <= 1'b0;
        end else begin
            if (advance) begin
                fetch_pc <= pc_update;
            end
            issue_valid <= issue_en;
        end
    end

    // payload of the old pc
    always_ff @(posedge clk) begin
        if (issue_en) begin
            issue_pipe <= pipe;
        end
    end

    assign issue = '{
        valid:       issue_valid,
        pc:          issue_pipe.pc,
        instruction: issue_pipe.instruction,
        prediction:  issue_pipe.prediction
    };

    // every fetch target stays on a word boundary
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        fetch_pc[1:0] == 2'b00);

    // issued record belongs to the pc fetched before the edge
    a_issue_from_fetch_pc: assert property (@(posedge clk) disable iff (rst)
        issue.valid |-> issue.pc == $past(fetch_pc));

    // back-pressure freezes fetch
    a_stall_holds_pc: assert property (@(posedge clk) disable iff (rst)
        (queue_full && !mispredicted) |=> $stable(fetch_pc));

endmodule

// ==== logic/fetch_predecode.sv ====
// ==========================================================
// fetch predecode
// flags branches and jal, makes the static prediction
// ==========================================================

`include "fe_defs.svh"

module fetch_predecode (
    input  logic [`FE_XLEN-1:0] fetch_pc,
    input  fe_pkg::rv_instr_u   instr,
    output fe_pkg::pipe_t       pipe
);

    logic is_branch;
    logic is_jump;
    logic predict_taken;

    // opcode sits in the same bits for every view
    always_comb begin
        is_branch     = 1'b0;
        is_jump       = 1'b0;
        predict_taken = 1'b0;
        case (instr.b_fmt.opcode)
            `FE_OPC_BRANCH: begin
                is_branch = 1'b1;
                // negative offset means a loop, so guess taken
                predict_taken = instr.b_fmt.imm12;
            end
            `FE_OPC_JAL: begin
                is_jump       = 1'b1;
                // always goes
                predict_taken = 1'b1;
            end
            `FE_OPC_JALR: begin
                // target comes from a register, not known here
                // fall through to pc + 4, commit repairs it
                is_branch     = 1'b0;
                is_jump       = 1'b0;
                predict_taken = 1'b0;
            end
            default: begin
                // alu, loads, stores etc
                is_branch     = 1'b0;
                is_jump       = 1'b0;
                predict_taken = 1'b0;
            end
        endcase
    end

    // record passed to next-pc logic and the pc register
    always_comb begin
        pipe             = '0;
        pipe.pc          = fetch_pc;
        pipe.instruction = instr;
        pipe.branch      = is_branch;
        pipe.jump        = is_jump;
        pipe.prediction  = predict_taken;
    end

endmodule

// ==== logic/new_pc.sv ====
// ==========================================================
// next pc
// static-prediction target, overridden by commit redirects
// mispredicted doubles as the back-end flush
// ==========================================================

`include "fe_defs.svh"

module new_pc (
    input  fe_pkg::pipe_t       pipe,
    input  fe_pkg::commit_t     commit,
    output logic                mispredicted,
    output logic [`FE_XLEN-1:0] pc_update
);

    localparam logic [`FE_XLEN-1:0] step = `FE_XLEN'(4);

    logic [`FE_XLEN-1:0] imm_b;
    logic [`FE_XLEN-1:0] imm_j;
    logic [`FE_XLEN-1:0] base;
    logic [`FE_XLEN-1:0] addend;
    logic                branch_miss;
    logic                wrong_taken;
    logic                jalr_miss;

    // sign-extended branch offset from the B view
    assign imm_b = {
        {(`FE_XLEN-13){pipe.instruction.b_fmt.imm12}},
        pipe.instruction.b_fmt.imm12,
        pipe.instruction.b_fmt.imm11,
        pipe.instruction.b_fmt.imm10_5,
        pipe.instruction.b_fmt.imm4_1,
        1'b0
    };

    // sign-extended jal offset from the J view
    assign imm_j = {
        {(`FE_XLEN-21){pipe.instruction.j_fmt.imm20}},
        pipe.instruction.j_fmt.imm20,
        pipe.instruction.j_fmt.imm19_12,
        pipe.instruction.j_fmt.imm11,
        pipe.instruction.j_fmt.imm10_1,
        1'b0
    };

    // guess and outcome disagree at the rob head
    assign branch_miss = commit.is_branch & (commit.taken ^ commit.result);
    // guessed taken, really fell through
    assign wrong_taken = commit.taken & ~commit.result;
    // predicted jalr target was wrong
    assign jalr_miss   = commit.jalr &
                         (commit.jalr_taken_address != commit.jalr_actual_address);

    assign mispredicted = branch_miss | jalr_miss;

    // pick operands, one shared adder below
    always_comb begin
        if (branch_miss) begin
            base = commit.pc;
            // taken by mistake: resume after the branch
            if (wrong_taken) begin
                addend = step;
            end else begin
                addend = commit.imm_se;
            end
        end else if (jalr_miss) begin
            // absolute target
            base   = '0;
            addend = commit.jalr_actual_address;
        end else if (pipe.branch & pipe.prediction) begin
            base   = pipe.pc;
            addend = imm_b;
        end else if (pipe.jump) begin
            base   = pipe.pc;
            addend = imm_j;
        end else begin
            // sequential, incl. jalr and forward branches
            base   = pipe.pc;
            addend = step;
        end
    end

    assign pc_update = base + addend;

endmodule

// ==== logic/pc_front.sv ====
// ==========================================================
// pc front end
// predecode, next-pc select and pc register in one loop
// ==========================================================

`include "fe_defs.svh"

module pc_front (
    input  logic                clk,
    input  logic                rst,
    input  fe_pkg::rv_instr_u   instr,
    input  logic                queue_full,
    input  fe_pkg::commit_t     commit,
    output logic [`FE_XLEN-1:0] fetch_pc,
    output logic                mispredicted,
    output fe_pkg::issue_t      issue
);

    fe_pkg::pipe_t       pipe;
    logic [`FE_XLEN-1:0] pc_update;

    // word at fetch_pc comes straight from imem
    fetch_predecode u_predecode (
        .fetch_pc (fetch_pc),
        .instr    (instr),
        .pipe     (pipe)
    );

    // combinational, same cycle as commit
    new_pc u_new_pc (
        .pipe         (pipe),
        .commit       (commit),
        .mispredicted (mispredicted),
        .pc_update    (pc_update)
    );

    fetch_pc_reg u_pc_reg (
        .clk          (clk),
        .rst          (rst),
        .queue_full   (queue_full),
        .mispredicted (mispredicted),
        .pc_update    (pc_update),
        .pipe         (pipe),
        .fetch_pc     (fetch_pc),
        .issue        (issue)
    );

endmodule

// ==== verif/pc_front_tb.sv ====
// ==========================================================
// pc front end testbench
// random fetch words, stalls and commit redirects checked
// against a cycle model of the next-pc rules
// ==========================================================

`include "fe_defs.svh"

module pc_front_tb;

    localparam int RESET_CYCLES   = 16;
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    logic                clk;
    logic                rst;
    fe_pkg::rv_instr_u   instr;
    logic                queue_full;
    fe_pkg::commit_t     commit;
    logic [`FE_XLEN-1:0] fetch_pc;
    logic                mispredicted;
    fe_pkg::issue_t      issue;

    // model state expected after the next edge
    logic [31:0] rng;
    logic [31:0] m_pc;
    logic        m_misp;
    logic        m_valid;
    logic [31:0] m_issue_pc;
    logic [31:0] m_issue_word;
    logic        m_issue_pred;
    logic        m_payload_seen;
    string       test_name;
    int          errors;
    int          checks;
    int          cycles;

    pc_front dut (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .queue_full   (queue_full),
        .commit       (commit),
        .fetch_pc     (fetch_pc),
        .mispredicted (mispredicted),
        .issue        (issue)
    );

    always #2 clk = ~clk;

    // hard stop in case the stimulus loop stalls
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // non-control opcodes op, op-imm, load, store and lui
    function automatic logic [6:0] alu_opcode(input logic [2:0] sel);
        case (sel)
            3'd1:    return 7'b0010011;
            3'd2:    return 7'b0000011;
            3'd3:    return 7'b0100011;
            3'd4:    return 7'b0110111;
            default: return 7'b0110011;
        endcase
    endfunction

    // B-type offset per the RV32 spec bit layout
    function automatic logic [31:0] b_offset(input logic [31:0] w);
        return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    endfunction

    // J-type offset per the RV32 spec bit layout
    function automatic logic [31:0] j_offset(input logic [31:0] w);
        return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h (cycle %0d)",
                 name, exp, act, cycles);
    endtask

    // outputs are steady at the falling edge
    task automatic check_outputs();
        checks++;
        if (fetch_pc !== m_pc) begin
            report_mismatch({test_name, " fetch_pc"}, m_pc, fetch_pc);
        end
        if (mispredicted !== m_misp) begin
            report_mismatch({test_name, " mispredicted"}, 32'(m_misp), 32'(mispredicted));
        end
        if (issue.valid !== m_valid) begin
            report_mismatch({test_name, " issue.valid"}, 32'(m_valid), 32'(issue.valid));
        end
        // payload is undefined until the first issue and holds after
        if (m_payload_seen) begin
            if (issue.pc !== m_issue_pc) begin
                report_mismatch({test_name, " issue.pc"}, m_issue_pc, issue.pc);
            end
            if (issue.instruction !== m_issue_word) begin
                report_mismatch({test_name, " issue.instruction"}, m_issue_word,
                                issue.instruction);
            end
            if (issue.prediction !== m_issue_pred) begin
                report_mismatch({test_name, " issue.prediction"}, 32'(m_issue_pred),
                                32'(issue.prediction));
            end
        end
    endtask

    // drive new inputs and step the model to the coming rising edge
    task automatic drive_and_predict();
        logic [31:0] pick;
        logic [31:0] word;
        logic [31:0] target;
        logic        pred;
        logic        branch_miss;
        logic        jalr_miss;
        logic        advance;
        string       kind;
        rng  = xorshift32(rng);
        pick = rng;
        rng  = xorshift32(rng);
        word = rng;
        pred = 1'b0;
        case (pick[2:0])
            3'd3: begin
                // forward branch with imm[1] cleared to keep targets aligned
                word[6:0] = `FE_OPC_BRANCH;
                word[31]  = 1'b0;
                word[8]   = 1'b0;
                kind      = "fwd_branch";
            end
            3'd4: begin
                word[6:0] = `FE_OPC_BRANCH;
                word[31]  = 1'b1;
                word[8]   = 1'b0;
                pred      = 1'b1;
                kind      = "back_branch";
            end
            3'd5: begin
                word[6:0] = `FE_OPC_JAL;
                word[21]  = 1'b0;
                pred      = 1'b1;
                kind      = "jal";
            end
            3'd6: begin
                word[6:0] = `FE_OPC_JALR;
                kind      = "jalr_fetch";
            end
            default: begin
                word[6:0] = alu_opcode(pick[5:3]);
                kind      = "alu_seq";
            end
        endcase
        queue_full = (pick[9:8] == 2'b00);
        commit     = '0;
        // roughly one commit event in eight cycles
        if (pick[14:12] == 3'b000) begin
            rng = xorshift32(rng);
            if (pick[15]) begin
                commit.is_branch = 1'b1;
                commit.taken     = rng[0];
                commit.result    = rng[1];
                commit.pc        = {rng[31:2], 2'b00};
                rng              = xorshift32(rng);
                commit.imm_se    = {{19{rng[12]}}, rng[12:2], 2'b00};
                // a wrong jalr in the same bundle must lose to a branch miss
                if (pick[16]) begin
                    commit.jalr                = 1'b1;
                    commit.jalr_actual_address = {rng[31:3], 3'b100};
                end
            end else begin
                commit.jalr                = 1'b1;
                commit.jalr_taken_address  = {rng[31:2], 2'b00};
                commit.jalr_actual_address = commit.jalr_taken_address;
                if (pick[16]) begin
                    commit.jalr_actual_address = commit.jalr_taken_address ^
                                                 {rng[28:3], 6'b000100};
                end
            end
        end
        instr = word;

        branch_miss = commit.is_branch && (commit.taken != commit.result);
        jalr_miss   = commit.jalr &&
                      (commit.jalr_taken_address != commit.jalr_actual_address);
        if (branch_miss) begin
            kind = "branch_redirect";
            if (commit.taken && !commit.result) begin
                target = commit.pc + 32'd4;
            end else begin
                target = commit.pc + commit.imm_se;
            end
        end else if (jalr_miss) begin
            kind   = "jalr_redirect";
            target = commit.jalr_actual_address;
        end else if (word[6:0] == `FE_OPC_BRANCH && word[31]) begin
            target = m_pc + b_offset(word);
        end else if (word[6:0] == `FE_OPC_JAL) begin
            target = m_pc + j_offset(word);
        end else begin
            target = m_pc + 32'd4;
        end
        m_misp  = branch_miss || jalr_miss;
        advance = !queue_full || m_misp;
        if (queue_full && !m_misp) begin
            kind = "queue_stall";
        end
        // record of the old pc goes out on a clean advance
        if (advance && !m_misp) begin
            m_issue_pc     = m_pc;
            m_issue_word   = word;
            m_issue_pred   = pred;
            m_payload_seen = 1'b1;
        end
        m_valid = advance && !m_misp;
        if (advance) begin
            m_pc = target;
        end
        test_name = kind;
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        instr          = '0;
        queue_full     = 1'b0;
        commit         = '0;
        rng            = 32'h4b192d75;
        m_pc           = `FE_RESET_PC;
        m_misp         = 1'b0;
        m_valid        = 1'b0;
        m_issue_pc     = '0;
        m_issue_word   = '0;
        m_issue_pred   = 1'b0;
        m_payload_seen = 1'b0;
        test_name      = "reset";
        errors         = 0;
        checks         = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // first pass checks the state left by reset
        for (int n = 0; n < TEST_CYCLES; n++) begin
            check_outputs();
            drive_and_predict();
            @(negedge clk);
        end
        check_outputs();

        $display("summary: %0d errors in %0d checked cycles", errors, checks);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
